// File: common/mips_defines.svh
`default_nettype none
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

`define MIPS_WORD_W     32
`define MIPS_REG_COUNT  32
`define MIPS_REG_ADDR_W 5
`define MIPS_RESET_PC   32'h0000_0000

// instruction fields, as part selects of the 32-bit word.
`define MIPS_OP_F     31:26
`define MIPS_RS_F     25:21
`define MIPS_RT_F     20:16
`define MIPS_RD_F     15:11
`define MIPS_SHAMT_F  10:6
`define MIPS_FUNCT_F  5:0
`define MIPS_IMM_F    15:0
`define MIPS_TARGET_F 25:0

`endif
`default_nettype wire

// File: common/mips_pkg.sv
`include "mips_defines.svh"
`default_nettype none

package mips_pkg;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0a,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_XORI    = 6'h0e,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SB      = 6'h28,
		OP_SW      = 6'h2b
	} opcode_t;

	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2a
	} funct_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLT, ALU_SLL, ALU_SRL, ALU_PASS_B
	} alu_op_t;

	typedef enum logic [1:0] {PC_NEXT, PC_BRANCH_EQ, PC_BRANCH_NE, PC_JUMP} pc_action_t;
	typedef enum logic [1:0] {WR_NONE, WR_RD, WR_RT, WR_R31} wr_dst_t;
	typedef enum logic [1:0] {WB_ALU, WB_MEMORY, WB_LINK} wb_src_t;
	typedef enum logic [1:0] {IMM_SIGNED, IMM_UNSIGNED, IMM_UPPER} imm_mode_t;

	typedef struct packed {
		alu_op_t    alu_op;
		logic       b_is_imm;
		logic       b_is_shamt; // shifts take rt on operand a and shamt on b.
		imm_mode_t  imm_mode;
		wr_dst_t    wr_dst;
		wb_src_t    wb_src;
		logic       mem_write;
		logic       mem_byte;
		logic       mem_read;
		pc_action_t pc_action;
	} ctrl_t;

	typedef struct packed {
		logic zero;
		logic equal;
	} alu_status_t;

	typedef struct packed {
		logic [`MIPS_WORD_W-1:0] addr; // full byte address.
		logic [`MIPS_WORD_W-1:0] wdata;
		logic [3:0]              be;
		logic                    we;
	} dmem_req_t;

endpackage

`default_nettype wire

// File: mips/mips_alu.sv
`timescale 1ns/1ps
`include "mips_defines.svh"
`default_nettype none

module mips_alu (
	input  mips_pkg::alu_op_t             alu_op,
	input  wire  [`MIPS_WORD_W-1:0]       a,
	input  wire  [`MIPS_WORD_W-1:0]       b,
	output logic [`MIPS_WORD_W-1:0]       result,
	output mips_pkg::alu_status_t         status
);
	import mips_pkg::*;

	logic less;

	assign less = $signed(a) < $signed(b);

	always_comb begin
		case (alu_op)
			ALU_ADD:    result = a + b;
			ALU_SUB:    result = a - b;
			ALU_AND:    result = a & b;
			ALU_OR:     result = a | b;
			ALU_XOR:    result = a ^ b;
			ALU_SLT:    result = {{(`MIPS_WORD_W-1){1'b0}}, less};
			ALU_SLL:    result = a << b[4:0]; // a holds rt for shifts.
			ALU_SRL:    result = a >> b[4:0];
			ALU_PASS_B: result = b;
			default:    result = '0;
		endcase
	end

	assign status.zero  = (result == '0);
	assign status.equal = (a == b); // drives beq and bne.

endmodule

`default_nettype wire

// File: mips/mips_pc.sv
`timescale 1ns/1ps
`include "mips_defines.svh"
`default_nettype none

module mips_pc (
	input  wire                         clk,
	input  wire                         reset,
	input  mips_pkg::pc_action_t        pc_action,
	input  mips_pkg::alu_status_t       status,
	input  wire  [15:0]                 offset,
	input  wire  [25:0]                 target,
	output logic [`MIPS_WORD_W-1:0]     pc,
	output logic [`MIPS_WORD_W-1:0]     pc_plus4
);
	import mips_pkg::*;

	logic [`MIPS_WORD_W-1:0] branch_addr;
	logic [`MIPS_WORD_W-1:0] jump_addr;
	logic [`MIPS_WORD_W-1:0] pc_next;

	assign pc_plus4    = pc + 32'd4;
	assign branch_addr = pc_plus4 + {{14{offset[15]}}, offset, 2'b00};
	assign jump_addr   = {pc_plus4[`MIPS_WORD_W-1 -: 4], target, 2'b00};

	always_comb begin
		case (pc_action)
			PC_BRANCH_EQ: pc_next = status.equal ? branch_addr : pc_plus4;
			PC_BRANCH_NE: pc_next = status.equal ? pc_plus4 : branch_addr;
			PC_JUMP:      pc_next = jump_addr;
			default:      pc_next = pc_plus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			pc <= `MIPS_RESET_PC;
		else
			pc <= pc_next;
	end

endmodule

`default_nettype wire

// File: mips/mips_regfile.sv
`timescale 1ns/1ps
`include "mips_defines.svh"
`default_nettype none

module mips_regfile (
	input  wire                          clk,
	input  wire  [`MIPS_REG_ADDR_W-1:0]  rs_addr,
	input  wire  [`MIPS_REG_ADDR_W-1:0]  rt_addr,
	output logic [`MIPS_WORD_W-1:0]      rs_data,
	output logic [`MIPS_WORD_W-1:0]      rt_data,
	input  wire  [`MIPS_REG_ADDR_W-1:0]  wr_addr,
	input  wire  [`MIPS_WORD_W-1:0]      wr_data,
	input  wire                          wr_en
);

	logic [`MIPS_WORD_W-1:0] regs [`MIPS_REG_COUNT];

	always_ff @(posedge clk) begin
		if (wr_en && (wr_addr != '0))
			regs[wr_addr] <= wr_data; // entry 0 is never written.
	end

	// Reads are combinational, so a write shows up in the next cycle.
	assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

// File: mips/mips_decode.sv
`timescale 1ns/1ps
`include "mips_defines.svh"
`default_nettype none

module mips_decode (
	input  wire                     reset,
	input  wire  [`MIPS_WORD_W-1:0] instruction,
	output mips_pkg::ctrl_t         ctrl
);
	import mips_pkg::*;

	opcode_t opcode;
	funct_t  funct;

	assign opcode = opcode_t'(instruction[`MIPS_OP_F]);
	assign funct  = funct_t'(instruction[`MIPS_FUNCT_F]);

	always_comb begin
		ctrl = '{alu_op: ALU_ADD, b_is_imm: 1'b0, b_is_shamt: 1'b0, imm_mode: IMM_SIGNED,
			wr_dst: WR_NONE, wb_src: WB_ALU, mem_write: 1'b0, mem_byte: 1'b0,
			mem_read: 1'b0, pc_action: PC_NEXT}; // the no-op.
		case (opcode)
			OP_SPECIAL: begin
				ctrl.wr_dst = WR_RD;
				case (funct)
					FN_ADDU: ctrl.alu_op = ALU_ADD;
					FN_SUBU: ctrl.alu_op = ALU_SUB;
					FN_AND:  ctrl.alu_op = ALU_AND;
					FN_OR:   ctrl.alu_op = ALU_OR;
					FN_XOR:  ctrl.alu_op = ALU_XOR;
					FN_SLT:  ctrl.alu_op = ALU_SLT;
					FN_SLL: begin
						ctrl.alu_op     = ALU_SLL;
						ctrl.b_is_shamt = 1'b1;
					end
					FN_SRL: begin
						ctrl.alu_op     = ALU_SRL;
						ctrl.b_is_shamt = 1'b1;
					end
					default: ctrl.wr_dst = WR_NONE; // unknown function codes change nothing.
				endcase
			end
			OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW: begin
				ctrl.b_is_imm = 1'b1;
				ctrl.wr_dst   = WR_RT;
				case (opcode)
					OP_SLTI: ctrl.alu_op = ALU_SLT;
					OP_ANDI: ctrl.alu_op = ALU_AND;
					OP_ORI:  ctrl.alu_op = ALU_OR;
					OP_XORI: ctrl.alu_op = ALU_XOR;
					OP_LUI:  ctrl.alu_op = ALU_PASS_B;
					default: ctrl.alu_op = ALU_ADD;
				endcase
				if (opcode inside {OP_ANDI, OP_ORI, OP_XORI})
					ctrl.imm_mode = IMM_UNSIGNED; // logic immediates are zero extended.
				if (opcode == OP_LUI)
					ctrl.imm_mode = IMM_UPPER;
				if (opcode == OP_LW) begin
					ctrl.wb_src   = WB_MEMORY;
					ctrl.mem_read = 1'b1;
				end
			end
			OP_SW, OP_SB: begin
				ctrl.b_is_imm  = 1'b1;
				ctrl.mem_write = 1'b1;
				ctrl.mem_byte  = (opcode == OP_SB);
			end
			OP_BEQ: begin
				ctrl.alu_op    = ALU_SUB;
				ctrl.pc_action = PC_BRANCH_EQ;
			end
			OP_BNE: begin
				ctrl.alu_op    = ALU_SUB;
				ctrl.pc_action = PC_BRANCH_NE;
			end
			OP_J: ctrl.pc_action = PC_JUMP;
			OP_JAL: begin
				ctrl.pc_action = PC_JUMP;
				ctrl.wr_dst    = WR_R31;
				ctrl.wb_src    = WB_LINK;
			end
			default: ;
		endcase
		if (reset) begin
			ctrl.mem_write = 1'b0; // nothing may reach memory or registers in reset.
			ctrl.wr_dst    = WR_NONE;
		end
	end

endmodule

`default_nettype wire

// File: mips/mips_operand_select.sv
`timescale 1ns/1ps
`include "mips_defines.svh"
`default_nettype none

module mips_operand_select (
	input  mips_pkg::ctrl_t               ctrl,
	input  wire  [`MIPS_WORD_W-1:0]       instruction,
	input  wire  [`MIPS_WORD_W-1:0]       pc_plus4,
	input  wire  [`MIPS_WORD_W-1:0]       rs_data,
	input  wire  [`MIPS_WORD_W-1:0]       rt_data,
	input  wire  [`MIPS_WORD_W-1:0]       alu_result,
	input  wire  [`MIPS_WORD_W-1:0]       dmem_rdata,
	output logic [`MIPS_WORD_W-1:0]       alu_a,
	output logic [`MIPS_WORD_W-1:0]       alu_b,
	output logic [`MIPS_REG_ADDR_W-1:0]   wr_addr,
	output logic                          wr_en,
	output logic [`MIPS_WORD_W-1:0]       wr_data,
	output mips_pkg::dmem_req_t           dmem_req
);
	import mips_pkg::*;

	logic [15:0]             imm;
	logic [`MIPS_WORD_W-1:0] imm_ext;

	assign imm = instruction[`MIPS_IMM_F];

	always_comb begin
		case (ctrl.imm_mode)
			IMM_UNSIGNED: imm_ext = {16'h0000, imm};
			IMM_UPPER:    imm_ext = {imm, 16'h0000};
			default:      imm_ext = {{16{imm[15]}}, imm};
		endcase
	end

	assign alu_a = ctrl.b_is_shamt ? rt_data : rs_data;
	assign alu_b = ctrl.b_is_shamt ? {27'd0, instruction[`MIPS_SHAMT_F]} :
		ctrl.b_is_imm ? imm_ext : rt_data;

	always_comb begin
		case (ctrl.wr_dst)
			WR_RD:   wr_addr = instruction[`MIPS_RD_F];
			WR_RT:   wr_addr = instruction[`MIPS_RT_F];
			WR_R31:  wr_addr = 5'd31;
			default: wr_addr = '0;
		endcase
		case (ctrl.wb_src)
			WB_MEMORY: wr_data = dmem_rdata;
			WB_LINK:   wr_data = pc_plus4; // no delay slot, so the link is pc plus 4.
			default:   wr_data = alu_result;
		endcase
	end

	assign wr_en = (ctrl.wr_dst != WR_NONE);

	always_comb begin
		dmem_req.addr  = (ctrl.mem_read || ctrl.mem_write) ? alu_result : '0;
		dmem_req.we    = ctrl.mem_write;
		dmem_req.wdata = ctrl.mem_byte ? {4{rt_data[7:0]}} : rt_data;
		dmem_req.be    = '0;
		if (ctrl.mem_write)
			dmem_req.be = ctrl.mem_byte ? (4'b0001 << alu_result[1:0]) : 4'b1111;
	end

endmodule

`default_nettype wire

// File: mips/mips_core.sv
`timescale 1ns/1ps
`include "mips_defines.svh"
`default_nettype none

module mips_core (
	input  wire                       clk,
	input  wire                       reset,
	output logic [`MIPS_WORD_W-1:0]   imem_addr,
	input  wire  [`MIPS_WORD_W-1:0]   imem_data,
	output mips_pkg::dmem_req_t       dmem_req,
	input  wire  [`MIPS_WORD_W-1:0]   dmem_rdata
);
	import mips_pkg::*;

	ctrl_t                       ctrl;
	alu_status_t                 alu_status;
	logic [`MIPS_REG_ADDR_W-1:0] rs_addr;
	logic [`MIPS_REG_ADDR_W-1:0] rt_addr;
	logic [`MIPS_REG_ADDR_W-1:0] wr_addr;
	logic [`MIPS_WORD_W-1:0]     rs_data;
	logic [`MIPS_WORD_W-1:0]     rt_data;
	logic [`MIPS_WORD_W-1:0]     wr_data;
	logic                        wr_en;
	logic [`MIPS_WORD_W-1:0]     alu_a;
	logic [`MIPS_WORD_W-1:0]     alu_b;
	logic [`MIPS_WORD_W-1:0]     alu_result;
	logic [`MIPS_WORD_W-1:0]     pc_plus4;
	logic [15:0]                 offset;
	logic [25:0]                 target;

	assign rs_addr = imem_data[`MIPS_RS_F];
	assign rt_addr = imem_data[`MIPS_RT_F];
	assign offset  = imem_data[`MIPS_IMM_F];
	assign target  = imem_data[`MIPS_TARGET_F];

	mips_decode i_decode (
		.reset       (reset),
		.instruction (imem_data),
		.ctrl        (ctrl)
	);

	mips_regfile i_regfile (
		.clk     (clk),
		.rs_addr (rs_addr),
		.rt_addr (rt_addr),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.wr_en   (wr_en)
	);

	mips_operand_select i_operand_select (
		.ctrl        (ctrl),
		.instruction (imem_data),
		.pc_plus4    (pc_plus4),
		.rs_data     (rs_data),
		.rt_data     (rt_data),
		.alu_result  (alu_result),
		.dmem_rdata  (dmem_rdata),
		.alu_a       (alu_a),
		.alu_b       (alu_b),
		.wr_addr     (wr_addr),
		.wr_en       (wr_en),
		.wr_data     (wr_data),
		.dmem_req    (dmem_req)
	);

	mips_alu i_alu (
		.alu_op (ctrl.alu_op),
		.a      (alu_a),
		.b      (alu_b),
		.result (alu_result),
		.status (alu_status)
	);

	mips_pc i_pc (
		.clk       (clk),
		.reset     (reset),
		.pc_action (ctrl.pc_action),
		.status    (alu_status),
		.offset    (offset),
		.target    (target),
		.pc        (imem_addr),
		.pc_plus4  (pc_plus4)
	);

endmodule

`default_nettype wire

// File: test/mips_checker.sv
`timescale 1ns/1ps
`include "mips_defines.svh"
`default_nettype none

module mips_checker (
	input wire                     clk,
	input wire                     reset,
	input wire [`MIPS_WORD_W-1:0]  imem_addr,
	input mips_pkg::dmem_req_t     dmem_req
);
	import mips_pkg::*;

	no_store_in_reset: assert property (@(posedge clk) reset |-> !dmem_req.we)
		else $error("store request raised while reset is high");

	byte_enable_shape: assert property (@(posedge clk)
		dmem_req.we |-> (dmem_req.be == 4'b1111 || $onehot(dmem_req.be)))
		else $error("store byte enables are neither a full word nor a single byte");

	fetch_aligned: assert property (@(posedge clk) !reset |-> imem_addr[1:0] == 2'b00)
		else $error("instruction address is not word aligned");

	// the first fetch after reset comes from address zero.
	start_at_zero: assert property (@(posedge clk) $fell(reset) |-> imem_addr == '0)
		else $error("first fetch after reset is not at address zero");

endmodule

bind mips_core mips_checker i_checker (
	.clk       (clk),
	.reset     (reset),
	.imem_addr (imem_addr),
	.dmem_req  (dmem_req)
);

`default_nettype wire

// File: test/tb_mips.sv
`timescale 1ns/1ps
`include "mips_defines.svh"
`default_nettype none

module tb_mips;
	import mips_pkg::*;

	localparam int PROG_LEN = 200;
	localparam int END_IDX  = 232; // index of the final self jump.

	logic        clk;
	logic        reset;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	dmem_req_t   dmem_req;
	logic [31:0] dmem_rdata;

	logic [31:0] prog [256];
	logic [31:0] dmem [logic [31:0]];
	logic [31:0] m_mem [logic [31:0]];
	logic [31:0] m_regs [32];
	logic [31:0] m_pc;
	bit          reg_ready [32];
	int          mem_version;
	int          dut_stores;
	int          model_stores;
	int          check_count;
	int          error_count;

	mips_core i_dut (
		.clk        (clk),
		.reset      (reset),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_req   (dmem_req),
		.dmem_rdata (dmem_rdata)
	);

	always #20 clk = ~clk;

	assign imem_data = prog[imem_addr[9:2]];

	// unwritten words read back a pattern made from their address.
	function automatic logic [31:0] fill_word(logic [31:0] addr);
		return {addr[15:0], ~addr[15:0]} ^ {addr[31:16], addr[31:16]};
	endfunction

	function automatic logic [31:0] read_dmem(logic [31:0] addr);
		logic [31:0] a;
		a = {addr[31:2], 2'b00};
		return dmem.exists(a) ? dmem[a] : fill_word(a);
	endfunction

	function automatic logic [31:0] read_model_mem(logic [31:0] addr);
		logic [31:0] a;
		a = {addr[31:2], 2'b00};
		return m_mem.exists(a) ? m_mem[a] : fill_word(a);
	endfunction

	always @(dmem_req.addr or mem_version) dmem_rdata = read_dmem(dmem_req.addr);

	always @(posedge clk) begin
		logic [31:0] w;
		if (dmem_req.we === 1'b1) begin
			w = read_dmem(dmem_req.addr);
			for (int k = 0; k < 4; k++)
				if (dmem_req.be[k])
					w[8*k +: 8] = dmem_req.wdata[8*k +: 8];
			dmem[{dmem_req.addr[31:2], 2'b00}] = w;
			dut_stores++;
			mem_version++;
		end
	end

	task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	function automatic logic [31:0] r_type(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
		logic [4:0] rd, logic [4:0] sh);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] i_type(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [4:0] pick_src();
		logic [4:0] r;
		r = 5'($urandom_range(0, 31));
		while (!reg_ready[r])
			r = 5'($urandom_range(0, 31));
		return r;
	endfunction

	// sources only come from registers written on every path, since the DUT file starts unknown.
	task automatic build_program();
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic [4:0]  rd;
		logic [15:0] imm;
		int          dst;
		int          lim;
		int          tgt;
		int          max_target;
		max_target = 0;
		foreach (prog[n])
			prog[n] = '0;
		foreach (reg_ready[n])
			reg_ready[n] = (n == 0);
		for (int i = 0; i < PROG_LEN; i++) begin
			rd  = 5'($urandom_range(0, 31));
			imm = 16'($urandom());
			ra  = pick_src();
			rb  = pick_src();
			dst = -1;
			lim = (PROG_LEN - 1 - i) < 4 ? (PROG_LEN - 1 - i) : 4;
			tgt = i + 1 + int'($urandom_range(0, lim));
			if (i < 8) begin
				if (i % 2 == 0)
					rd = 5'($urandom_range(1, 31));
				else
					rd = prog[i - 1][20:16];
				prog[i] = i_type((i % 2 == 0) ? 6'h0f : 6'h0d, rd, rd, imm);
				dst = rd;
			end else begin
				case ($urandom_range(0, 9))
					0, 1: begin
						case ($urandom_range(0, 5))
							0: prog[i] = r_type(6'h21, ra, rb, rd, 5'd0);
							1: prog[i] = r_type(6'h23, ra, rb, rd, 5'd0);
							2: prog[i] = r_type(6'h24, ra, rb, rd, 5'd0);
							3: prog[i] = r_type(6'h25, ra, rb, rd, 5'd0);
							4: prog[i] = r_type(6'h26, ra, rb, rd, 5'd0);
							default: prog[i] = r_type(6'h2a, ra, rb, rd, 5'd0);
						endcase
						dst = rd;
					end
					2: begin
						prog[i] = r_type($urandom_range(0, 1) ? 6'h02 : 6'h00, 5'd0, rb, rd,
							5'($urandom_range(0, 31)));
						dst = rd;
					end
					3, 4: begin
						case ($urandom_range(0, 5))
							0: prog[i] = i_type(6'h09, ra, rd, imm);
							1: prog[i] = i_type(6'h0a, ra, rd, imm);
							2: prog[i] = i_type(6'h0c, ra, rd, imm);
							3: prog[i] = i_type(6'h0d, ra, rd, imm);
							4: prog[i] = i_type(6'h0e, ra, rd, imm);
							default: prog[i] = i_type(6'h0f, 5'd0, rd, imm);
						endcase
						dst = rd;
					end
					5: begin
						prog[i] = i_type(6'h23, 5'd0, rd, 16'(32'h800 + 4 * $urandom_range(0, 63)));
						dst = rd;
					end
					6: prog[i] = i_type(6'h2b, 5'd0, rb, 16'(32'h800 + 4 * $urandom_range(0, 63)));
					7: prog[i] = i_type(6'h28, 5'd0, rb, 16'(32'h800 + $urandom_range(0, 255)));
					8: begin
						if ($urandom_range(0, 1))
							rb = ra; // forces a taken beq now and then.
						prog[i] = i_type($urandom_range(0, 1) ? 6'h05 : 6'h04, ra, rb,
							16'(tgt - i - 1));
						max_target = (tgt > max_target) ? tgt : max_target;
					end
					default: begin
						prog[i] = {$urandom_range(0, 1) ? 6'h03 : 6'h02, 26'(tgt)};
						if (prog[i][31:26] == 6'h03)
							dst = 31;
						max_target = (tgt > max_target) ? tgt : max_target;
					end
				endcase
			end
			if (dst > 0 && i >= max_target)
				reg_ready[dst] = 1'b1;
		end
		for (int r = 0; r < 32; r++)
			prog[PROG_LEN + r] = i_type(6'h2b, 5'd0, 5'(r), 16'(32'h1000 + 4 * r));
		prog[END_IDX] = {6'h02, 26'(END_IDX)};
	endtask

	task automatic write_reg(logic [4:0] r, logic [31:0] value);
		if (r != 0)
			m_regs[r] = value;
	endtask

	// one instruction of the reference interpreter, no delay slot.
	task automatic step_model(logic [31:0] ins);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sx;
		logic [31:0] zx;
		logic [31:0] next;
		logic [31:0] w;
		logic [31:0] ea;
		a    = m_regs[ins[25:21]];
		b    = m_regs[ins[20:16]];
		sx   = {{16{ins[15]}}, ins[15:0]};
		zx   = {16'h0000, ins[15:0]};
		next = m_pc + 32'd4;
		ea   = a + sx;
		case (ins[31:26])
			6'h00: case (ins[5:0])
				6'h21: write_reg(ins[15:11], a + b);
				6'h23: write_reg(ins[15:11], a - b);
				6'h24: write_reg(ins[15:11], a & b);
				6'h25: write_reg(ins[15:11], a | b);
				6'h26: write_reg(ins[15:11], a ^ b);
				6'h2a: write_reg(ins[15:11], {31'd0, $signed(a) < $signed(b)});
				6'h00: write_reg(ins[15:11], b << ins[10:6]);
				6'h02: write_reg(ins[15:11], b >> ins[10:6]);
				default: ;
			endcase
			6'h09: write_reg(ins[20:16], ea);
			6'h0a: write_reg(ins[20:16], {31'd0, $signed(a) < $signed(sx)});
			6'h0c: write_reg(ins[20:16], a & zx);
			6'h0d: write_reg(ins[20:16], a | zx);
			6'h0e: write_reg(ins[20:16], a ^ zx);
			6'h0f: write_reg(ins[20:16], {ins[15:0], 16'h0000});
			6'h23: write_reg(ins[20:16], read_model_mem(ea));
			6'h2b: begin
				m_mem[{ea[31:2], 2'b00}] = b;
				model_stores++;
			end
			6'h28: begin
				w = read_model_mem(ea);
				w[8*ea[1:0] +: 8] = b[7:0];
				m_mem[{ea[31:2], 2'b00}] = w;
				model_stores++;
			end
			6'h04: if (a == b) next = next + {sx[29:0], 2'b00};
			6'h05: if (a != b) next = next + {sx[29:0], 2'b00};
			6'h02: next = {next[31:28], ins[25:0], 2'b00};
			6'h03: begin
				write_reg(5'd31, next);
				next = {next[31:28], ins[25:0], 2'b00};
			end
			default: ;
		endcase
		m_pc = next;
	endtask

	task automatic check_request(logic [31:0] ins);
		logic [31:0] ea;
		logic        is_store;
		logic [3:0]  byte_lane;
		ea       = m_regs[ins[25:21]] + {{16{ins[15]}}, ins[15:0]};
		is_store = (ins[31:26] == 6'h2b) || (ins[31:26] == 6'h28);
		byte_lane = '0;
		byte_lane[ea[1:0]] = 1'b1; // sb touches only the addressed byte.
		check("store enable", {31'd0, is_store}, {31'd0, dmem_req.we});
		if (is_store) begin
			check("store address", ea, dmem_req.addr);
			if (ins[31:26] == 6'h2b) begin
				check("store data", m_regs[ins[20:16]], dmem_req.wdata);
				check("store byte enables", 32'hf, {28'd0, dmem_req.be});
			end else begin
				check("store data", {4{m_regs[ins[20:16]][7:0]}}, dmem_req.wdata);
				check("store byte enables", {28'd0, byte_lane}, {28'd0, dmem_req.be});
			end
		end
	endtask

	initial begin
		logic [31:0] ins;
		int          cycles;
		bit          done;
		clk   = 1'b0;
		reset = 1'b1;
		void'($urandom(75));
		build_program();
		foreach (m_regs[n])
			m_regs[n] = (n == 0) ? 32'd0 : 'x;
		m_pc   = `MIPS_RESET_PC;
		cycles = 0;
		done   = 1'b0;
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;
		while (!done && cycles < 2000) begin
			@(negedge clk);
			ins = prog[m_pc[9:2]];
			check("fetch address", m_pc, imem_addr);
			check_request(ins);
			if (ins[31:26] == 6'h02 && {m_pc[31:28], ins[25:0], 2'b00} == m_pc)
				done = 1'b1;
			else
				step_model(ins);
			cycles++;
		end
		if (!done) begin
			error_count++;
			$display("ERROR: the program never reached its final self jump within 2000 cycles");
		end else begin
			foreach (m_mem[a])
				check($sformatf("memory word %h", a), m_mem[a], read_dmem(a));
			check("written word count", m_mem.size(), dmem.size());
			check("store count", model_stores, dut_stores);
		end
		$display("checks %0d, errors %0d, stores %0d, cycles %0d",
			check_count, error_count, dut_stores, cycles);
		if (error_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+common
common/mips_pkg.sv
mips/mips_alu.sv
mips/mips_pc.sv
mips/mips_regfile.sv
mips/mips_decode.sv
mips/mips_operand_select.sv
mips/mips_core.sv
test/mips_checker.sv
test/tb_mips.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) common/mips_defines.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)
